// File: Bender.yml
package:
  name: csr_file

sources:
  - files:
      - verilog/csr_addr_pkg.sv
      - verilog/csr_data_pkg.sv
      - verilog/csr_decode_if.sv
      - verilog/csr_decode.sv
      - verilog/csr_execute.sv
      - verilog/csr_result.sv
      - verilog/csr_top.sv
  - target: simulation
    files:
      - verif/csr_tb.sv

// File: list.f
verilog/csr_addr_pkg.sv
verilog/csr_data_pkg.sv
verilog/csr_decode_if.sv
verilog/csr_decode.sv
verilog/csr_execute.sv
verilog/csr_result.sv
verilog/csr_top.sv
verif/csr_tb.sv

// File: verif/csr_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_tb;
	import csr_addr_pkg::*;
	import csr_data_pkg::*;

	logic      clk;
	logic      rst;
	csr_addr_t csr_addr;
	logic      wr_en;
	csr_word_t wr_data;
	csr_word_t rd_data;
	logic      write_fault;

	// reference state
	csr_word_t   model [26];
	logic        exp_fault;
	csr_word_t   exp_rd;
	logic [31:0] lfsr_state;
	int          read_checks;
	int          fault_checks;
	int          faults_seen;

	csr_top u_csr_top (
		.clk_i         (clk),
		.rst_i         (rst),
		.csr_addr_i    (csr_addr),
		.wr_en_i       (wr_en),
		.wr_data_i     (wr_data),
		.rd_data_o     (rd_data),
		.write_fault_o (write_fault)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// address of each writable slot in the privileged map
	function automatic csr_addr_t slot_address(input int s);
		case (s)
			0: return 12'h105;
			1: return 12'h180;
			2: return 12'h302;
			3: return 12'h303;
			4: return 12'h304;
			5: return 12'h305;
			default: begin
				if (s < 10) begin
					return 12'h3a0 + csr_addr_t'(s - 6);
				end
				return 12'h3b0 + csr_addr_t'(s - 10);
			end
		endcase
	endfunction

	// slot that holds an address or -1 when it has no storage
	function automatic int find_slot(input csr_addr_t a);
		for (int s = 0; s < 26; s++) begin
			if (slot_address(s) == a) begin
				return s;
			end
		end
		return -1;
	endfunction

	function automatic logic is_info(input csr_addr_t a);
		return (a >= 12'hf11) && (a <= 12'hf14);
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic drive(input csr_addr_t a, input logic we, input csr_word_t d);
		@(negedge clk);
		csr_addr = a;
		wr_en    = we;
		wr_data  = d;
	endtask

	task automatic read_all_slots();
		for (int s = 0; s < 26; s++) begin
			drive(slot_address(s), 1'b0, '0);
		end
	endtask

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	always @(posedge clk) begin : model_update
		int s;
		s = find_slot(csr_addr);
		if (rst) begin
			for (int i = 0; i < 26; i++) begin
				model[i] <= '0;
			end
			exp_fault <= 1'b0;
		end else begin
			if (wr_en && (s >= 0)) begin
				model[s] <= wr_data;
			end
			exp_fault <= wr_en && is_info(csr_addr);
		end
	end

	assign exp_rd = (find_slot(csr_addr) >= 0) ? model[find_slot(csr_addr)] : '0;

	read_a: assert property (@(posedge clk) disable iff (rst) rd_data == exp_rd) begin
		read_checks++;
	end else begin
		report_mismatch($sformatf("read of %h gave %h, expected %h",
			$sampled(csr_addr), $sampled(rd_data), $sampled(exp_rd)));
	end

	// passing checks with the flag expected high count the faults seen
	fault_a: assert property (@(posedge clk) disable iff (rst) write_fault == exp_fault) begin
		fault_checks++;
		if ($sampled(exp_fault)) begin
			faults_seen++;
		end
	end else begin
		report_mismatch($sformatf("write_fault_o is %b, expected %b",
			$sampled(write_fault), $sampled(exp_fault)));
	end

	initial begin
		for (int n = 0; n < 5000; n++) begin
			@(posedge clk);
		end
		$display("stimulus did not complete within 5000 clock cycles");
		$display("Simulation finished: FAIL");
		$fatal(1);
	end

	initial begin : stimulus
		logic [31:0] r;
		csr_addr_t   raz_list [8];
		rst          = 1'b1;
		csr_addr     = '0;
		wr_en        = 1'b0;
		wr_data      = '0;
		lfsr_state   = 32'he262;
		read_checks  = 0;
		fault_checks = 0;
		faults_seen  = 0;
		// mstatus, mepc, mcycle, mhpmevent3, tdata1, dpc, mscratch, mcause
		raz_list = '{12'h300, 12'h341, 12'hb00, 12'h323, 12'h7a1, 12'h7b1, 12'h340, 12'h342};
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// all slots read zero after reset
		read_all_slots();

		// write each slot and read it back next cycle
		for (int s = 0; s < 26; s++) begin
			rand_bits(32, r);
			drive(slot_address(s), 1'b1, r);
			drive(slot_address(s), 1'b0, '0);
		end
		read_all_slots();

		// read-as-zero addresses take no data
		foreach (raz_list[i]) begin
			rand_bits(32, r);
			drive(raz_list[i], 1'b1, r);
			drive(raz_list[i], 1'b0, '0);
		end
		read_all_slots();

		// random addresses outside the writable and info sets
		for (int k = 0; k < 40; k++) begin
			rand_bits(12, r);
			if ((find_slot(r[11:0]) < 0) && !is_info(r[11:0])) begin
				drive(r[11:0], 1'b0, '0);
				rand_bits(32, r);
				drive(csr_addr, 1'b1, r);
			end
		end
		read_all_slots();

		// info group writes raise the fault flag for one cycle
		for (int a = 12'hf11; a <= 12'hf14; a++) begin
			rand_bits(32, r);
			drive(csr_addr_t'(a), 1'b1, r);
			drive(slot_address(a - 12'hf11), 1'b0, '0);
			drive(csr_addr_t'(a), 1'b0, r);
			drive(slot_address(5), 1'b1, r);
			drive(slot_address(5), 1'b0, '0);
		end

		// back-to-back writes and the same traffic with the strobe low
		for (int s = 25; s >= 0; s--) begin
			rand_bits(32, r);
			drive(slot_address(s), 1'b1, r);
		end
		read_all_slots();
		for (int s = 0; s < 26; s++) begin
			rand_bits(32, r);
			drive(slot_address(s), 1'b0, r);
		end
		read_all_slots();

		@(negedge clk);
		if ((read_checks > 0) && (fault_checks > 0) && (faults_seen == 4)) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("checks were not all reached during the run");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: verilog/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

	// 12-bit CSR address as seen on the CSR port
	typedef logic [11:0] csr_addr_t;

	// index into the writable register storage
	typedef logic [4:0] csr_slot_t;

	// writable registers: 6 named, 4 pmpcfg, 16 pmpaddr
	localparam int unsigned CSR_SLOTS = 26;

	// supervisor trap setup and address translation
	localparam csr_addr_t CSR_STVEC = 12'h105;
	localparam csr_addr_t CSR_SATP  = 12'h180;

	// machine trap setup
	localparam csr_addr_t CSR_MEDELEG = 12'h302;
	localparam csr_addr_t CSR_MIDELEG = 12'h303;
	localparam csr_addr_t CSR_MIE     = 12'h304;
	localparam csr_addr_t CSR_MTVEC   = 12'h305;

	// physical memory protection, contiguous ranges
	localparam csr_addr_t CSR_PMPCFG_BASE  = 12'h3a0;
	localparam csr_addr_t CSR_PMPADDR_BASE = 12'h3b0;

	// number of entries in each pmp range
	localparam csr_addr_t PMPCFG_COUNT  = 12'd4;
	localparam csr_addr_t PMPADDR_COUNT = 12'd16;

	// machine information group, mvendorid up to mhartid
	// these are read-only, a write to them is a fault
	localparam csr_addr_t CSR_INFO_BASE = 12'hf11;
	localparam csr_addr_t CSR_INFO_LAST = 12'hf14;

	// slot numbers of the named registers
	localparam csr_slot_t SLOT_STVEC   = 5'd0;
	localparam csr_slot_t SLOT_SATP    = 5'd1;
	localparam csr_slot_t SLOT_MEDELEG = 5'd2;
	localparam csr_slot_t SLOT_MIDELEG = 5'd3;
	localparam csr_slot_t SLOT_MIE     = 5'd4;
	localparam csr_slot_t SLOT_MTVEC   = 5'd5;

	// first slot of each pmp range, entries follow in address order
	localparam csr_slot_t SLOT_PMPCFG0  = 5'd6;
	localparam csr_slot_t SLOT_PMPADDR0 = 5'd10;

endpackage

`default_nettype wire

// File: verilog/csr_data_pkg.sv
`default_nettype none

package csr_data_pkg;

	// one CSR value, RV32
	typedef logic [31:0] csr_word_t;

	// every writable register comes out of reset as zero
	localparam csr_word_t CSR_RESET_VALUE = 32'h0000_0000;

endpackage

`default_nettype wire

// File: verilog/csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
	input  csr_addr_pkg::csr_addr_t csr_addr_i,
	input  logic                    wr_en_i,
	csr_decode_if.decode_mp         dec
);
	import csr_addr_pkg::*;

	csr_addr_t pmpcfg_off;
	csr_addr_t pmpaddr_off;
	logic      pmpcfg_hit;
	logic      pmpaddr_hit;

	// offset from each range base, wraps to a large value below the base
	// so a single unsigned compare covers both ends of the range
	assign pmpcfg_off  = csr_addr_i - CSR_PMPCFG_BASE;
	assign pmpaddr_off = csr_addr_i - CSR_PMPADDR_BASE;

	assign pmpcfg_hit  = pmpcfg_off < PMPCFG_COUNT;
	assign pmpaddr_hit = pmpaddr_off < PMPADDR_COUNT;

	// slot lookup
	always_comb begin
		dec.slot     = '0;
		dec.slot_hit = 1'b1;
		if (pmpcfg_hit) begin
			dec.slot = SLOT_PMPCFG0 + pmpcfg_off[4:0];
		end else if (pmpaddr_hit) begin
			dec.slot = SLOT_PMPADDR0 + pmpaddr_off[4:0];
		end else begin
			case (csr_addr_i)
				CSR_STVEC: begin
					dec.slot = SLOT_STVEC;
				end
				CSR_SATP: begin
					dec.slot = SLOT_SATP;
				end
				CSR_MEDELEG: begin
					dec.slot = SLOT_MEDELEG;
				end
				CSR_MIDELEG: begin
					dec.slot = SLOT_MIDELEG;
				end
				CSR_MIE: begin
					dec.slot = SLOT_MIE;
				end
				CSR_MTVEC: begin
					dec.slot = SLOT_MTVEC;
				end
				// everything else has no storage and reads as zero
				default: begin
					dec.slot_hit = 1'b0;
				end
			endcase
		end
	end

	// mvendorid, marchid, mimpid, mhartid
	assign dec.info_hit = (csr_addr_i >= CSR_INFO_BASE) && (csr_addr_i <= CSR_INFO_LAST);

	// write enable goes through untouched, execute and result qualify it
	assign dec.wr_strobe = wr_en_i;

	// range arithmetic must never point past the storage array
	slot_in_range_a: assert final (!dec.slot_hit || (dec.slot < CSR_SLOTS));

endmodule

`default_nettype wire

// File: verilog/csr_decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_decode_if;
	import csr_addr_pkg::*;

	// storage slot picked by the address, valid with slot_hit
	csr_slot_t slot;
	logic      slot_hit;
	// address lies in the read-only information group
	logic      info_hit;
	logic      wr_strobe;

	modport decode_mp (
		output slot,
		output slot_hit,
		output info_hit,
		output wr_strobe
	);

	modport execute_mp (
		input slot,
		input slot_hit,
		input wr_strobe
	);

	modport result_mp (
		input slot,
		input slot_hit,
		input info_hit,
		input wr_strobe
	);

endinterface

`default_nettype wire

// File: verilog/csr_execute.sv
`timescale 1ns/1ps
`default_nettype none

module csr_execute (
	input  logic                    clk_i,
	input  logic                    rst_i,
	csr_decode_if.execute_mp        dec,
	input  csr_data_pkg::csr_word_t wr_data_i,
	output csr_data_pkg::csr_word_t regs_o [csr_addr_pkg::CSR_SLOTS]
);
	import csr_addr_pkg::*;
	import csr_data_pkg::*;

	csr_word_t regs_q [CSR_SLOTS];
	logic      wr_fire;

	// only addresses with storage take a write
	assign wr_fire = dec.wr_strobe && dec.slot_hit;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < CSR_SLOTS; i++) begin
				regs_q[i] <= CSR_RESET_VALUE;
			end
		end else if (wr_fire) begin
			regs_q[dec.slot] <= wr_data_i;
		end
	end

	assign regs_o = regs_q;

	// a register holds its value unless a write was presented the cycle before
	for (genvar g = 0; g < CSR_SLOTS; g++) begin : g_hold_chk
		slot_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
			(!$past(rst_i) && !$past(dec.wr_strobe)) |-> $stable(regs_q[g]));
	end

endmodule

`default_nettype wire

// File: verilog/csr_result.sv
`timescale 1ns/1ps
`default_nettype none

module csr_result (
	input  logic                    clk_i,
	input  logic                    rst_i,
	csr_decode_if.result_mp         dec,
	input  csr_data_pkg::csr_word_t regs_i [csr_addr_pkg::CSR_SLOTS],
	output csr_data_pkg::csr_word_t rd_data_o,
	output logic                    write_fault_o
);
	import csr_addr_pkg::*;
	import csr_data_pkg::*;

	logic write_fault_q;
	logic info_write;

	// read path is purely combinational, zero cycles from address to data
	// unmapped and read-as-zero addresses return zero
	assign rd_data_o = dec.slot_hit ? regs_i[dec.slot] : '0;

	// attempted write to a read-only information register
	assign info_write = dec.wr_strobe && dec.info_hit;

	// flag is high for exactly the cycle after the offending write
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			write_fault_q <= 1'b0;
		end else begin
			write_fault_q <= info_write;
		end
	end

	assign write_fault_o = write_fault_q;

	// the information group has no storage, so the two decodes are disjoint
	hit_exclusive_a: assert property (@(posedge clk_i) disable iff (rst_i)
		!(dec.slot_hit && dec.info_hit));

endmodule

`default_nettype wire

// File: verilog/csr_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_top (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  csr_addr_pkg::csr_addr_t csr_addr_i,
	input  logic                    wr_en_i,
	input  csr_data_pkg::csr_word_t wr_data_i,
	output csr_data_pkg::csr_word_t rd_data_o,
	output logic                    write_fault_o
);
	import csr_addr_pkg::*;
	import csr_data_pkg::*;

	// register contents, from execute to the read mux
	csr_word_t regs [CSR_SLOTS];

	// decoded address shared by all three stages
	csr_decode_if dec_if ();

	csr_decode u_decode (
		.csr_addr_i (csr_addr_i),
		.wr_en_i    (wr_en_i),
		.dec        (dec_if.decode_mp)
	);

	csr_execute u_execute (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.dec       (dec_if.execute_mp),
		.wr_data_i (wr_data_i),
		.regs_o    (regs)
	);

	csr_result u_result (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.dec           (dec_if.result_mp),
		.regs_i        (regs),
		.rd_data_o     (rd_data_o),
		.write_fault_o (write_fault_o)
	);

endmodule

`default_nettype wire
